// File: sim.f
+incdir+tests
hw/fp_pkg.sv
hw/mant_mul.sv
hw/fp_add.sv
hw/fp_mul.sv
hw/fp_unit.sv
tests/fp_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f sim.f \
    --top-module fp_unit_tb -o fp_unit_tb_sim

./obj_dir/fp_unit_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

// File: tests/fp_vectors.svh
`ifndef FP_VECTORS_SVH
`define FP_VECTORS_SVH

// Each row holds op, a, b and the expected result as raw binary32 words.
// Op sits in bits 97:96, a in 95:64, b in 63:32 and the expected word in 31:0.
localparam int num_vectors = 15;

localparam logic [97:0] vectors [num_vectors] = '{
    {op_add, 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000},  // 1.5 + 2.25 = 3.75
    {op_mul, 32'hbfc0_0000, 32'h4000_0000, 32'hc040_0000},  // -1.5 * 2.0 = -3.0
    {op_add, 32'h4100_0000, 32'h3f00_0000, 32'h4108_0000},  // 8.0 + 0.5 = 8.5
    {op_sub, 32'h40a0_0000, 32'h3fc0_0000, 32'h4060_0000},  // 5.0 - 1.5 = 3.5
    {op_mul, 32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000},  // 1.0 * 1.0 = 1.0
    {op_add, 32'h4040_0000, 32'h3f80_0000, 32'h4080_0000},  // 3.0 + 1.0 = 4.0
    {op_sub, 32'h3f80_0000, 32'h3f40_0000, 32'h3e80_0000},  // 1.0 - 0.75 = 0.25
    {op_mul, 32'h4040_0000, 32'h0000_0000, 32'h0000_0000},  // 3.0 * 0 = +0
    {op_sub, 32'h4000_0000, 32'h4000_0000, 32'h0000_0000},  // 2.0 - 2.0 = +0
    {op_mul, 32'h3fc0_0000, 32'h3fc0_0000, 32'h4010_0000},  // 1.5 * 1.5 = 2.25
    {op_add, 32'hc000_0000, 32'hbf80_0000, 32'hc040_0000},  // -2.0 + -1.0 = -3.0
    {op_sub, 32'h3fc0_0000, 32'h40a0_0000, 32'hc060_0000},  // 1.5 - 5.0 = -3.5
    {op_mul, 32'h4020_0000, 32'h4040_0000, 32'h40f0_0000},  // 2.5 * 3.0 = 7.5
    {op_add, 32'hbfc0_0000, 32'h3e80_0000, 32'hbfa0_0000},  // -1.5 + 0.25 = -1.25
    {op_mul, 32'hc000_0000, 32'hbf00_0000, 32'h3f80_0000}   // -2.0 * -0.5 = 1.0
};

`endif

// File: tests/fp_unit_tb.sv
`timescale 1ns/10ps

module fp_unit_tb;

    import fp_pkg::*;

    `include "fp_vectors.svh"

    localparam int timeout_cycles = 200;

    logic     clk;
    logic     rst;
    logic     start;
    fp_op_e   op;
    fp_word_u a;
    fp_word_u b;
    fp_word_u result;
    logic     ready;

    fp_unit #(
        .mul_bits(6)
    ) UUT (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .op    (op),
        .a     (a),
        .b     (b),
        .result(result),
        .ready (ready)
    );

    always #5 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "mismatch");
        end
    endtask

    // Inputs change 1 ns after the edge.
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input fp_op_e op_in, input logic [31:0] a_in,
                         input logic [31:0] b_in);
        op    = op_in;
        a.raw = a_in;
        b.raw = b_in;
        start = 1'b1;
        step_cycle();
        start = 1'b0;
    endtask

    // Result must not move while the unit is busy.
    task automatic wait_ready(input logic [31:0] held, input string what);
        int cycles;
        cycles = 0;
        while (!ready) begin
            check_value(result.raw, held, {what, " result held while busy"});
            if (cycles == timeout_cycles) begin
                $display("Timeout: ready never came back for %s", what);
                $display("Errors found");
                $fatal(1, "timeout");
            end
            step_cycle();
            cycles++;
        end
    endtask

    task automatic run_row(input int idx);
        logic [31:0] held;
        string       name;
        held = result.raw;
        name = $sformatf("row %0d", idx);
        issue(fp_op_e'(vectors[idx][97:96]), vectors[idx][95:64], vectors[idx][63:32]);
        check_value(32'(ready), 32'd0, {name, " ready after start"});
        wait_ready(held, name);
        check_value(result.raw, vectors[idx][31:0], name);
    endtask

    // ====================
    // Sequence
    // ====================

    initial begin
        logic [31:0] held;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        op    = op_add;
        a.raw = '0;
        b.raw = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value(32'(ready), 32'd1, "ready after reset");
        check_value(result.raw, 32'd0, "result after reset");

        // Mixed operations back to back.
        for (int i = 0; i < num_vectors; i++) begin
            run_row(i);
        end

        // A start while busy must be dropped.
        held = result.raw;
        issue(fp_op_e'(vectors[0][97:96]), vectors[0][95:64], vectors[0][63:32]);
        check_value(32'(ready), 32'd0, "ready after first start");
        issue(op_mul, vectors[1][95:64], vectors[1][63:32]);
        check_value(32'(ready), 32'd0, "ready after ignored start");
        wait_ready(held, "start while busy");
        check_value(result.raw, vectors[0][31:0], "result after ignored start");

        $display("No errors");
        $finish;
    end

endmodule

// File: hw/fp_unit.sv
`timescale 1ns/10ps

module fp_unit #(
    parameter int mul_bits = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fp_pkg::fp_op_e   op,
    input  fp_pkg::fp_word_u a,
    input  fp_pkg::fp_word_u b,
    output fp_pkg::fp_word_u result,
    output logic             ready
);

    import fp_pkg::*;

    logic     busy;
    fp_op_e   op_q;
    logic     accept;
    logic     add_start;
    logic     mul_start;
    logic     add_ready;
    logic     mul_ready;
    logic     sel_ready;
    fp_word_u add_result;
    fp_word_u mul_result;
    fp_word_u sel_result;
    fp_word_u result_q;

    // Starts while busy are dropped.
    assign accept    = start && !busy;
    assign add_start = accept && (op != op_mul);
    assign mul_start = accept && (op == op_mul);

    assign sel_ready  = (op_q == op_mul) ? mul_ready : add_ready;
    assign sel_result = (op_q == op_mul) ? mul_result : add_result;

    fp_add u_fp_add (
        .clk   (clk),
        .rst   (rst),
        .start (add_start),
        .sub   (op == op_sub),
        .a     (a),
        .b     (b),
        .result(add_result),
        .ready (add_ready)
    );

    fp_mul #(
        .mul_bits(mul_bits)
    ) u_fp_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .a     (a),
        .b     (b),
        .result(mul_result),
        .ready (mul_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            op_q         <= op_add;
            result_q.raw <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            op_q <= op;
        end else if (busy && sel_ready) begin
            busy     <= 1'b0;
            result_q <= sel_result;
        end
    end

    assign result = result_q;
    assign ready  = !busy;

endmodule

// File: hw/fp_mul.sv
`timescale 1ns/10ps

module fp_mul #(
    parameter int mul_bits = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fp_pkg::fp_word_u a,
    input  fp_pkg::fp_word_u b,
    output fp_pkg::fp_word_u result,
    output logic             ready
);

    import fp_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_smult,
        st_mult,
        st_norm
    } state_e;

    // Product of two 1.x mantissas lands one binade up.
    localparam logic [exp_w-1:0] bias_adj = exp_w'(exp_bias - 1);

    state_e              state;
    fp_word_u            a_q;
    fp_word_u            b_q;
    logic [mant_w-1:0]   mant_a;
    logic [mant_w-1:0]   mant_b;
    logic                mul_start;
    logic                mul_ready;
    logic [2*mant_w-1:0] mul_product;
    logic [2*mant_w-1:0] prod;
    logic                res_sign;
    logic [exp_w-1:0]    res_exp;

    assign mant_a = (a_q.f.exp == '0) ? '0 : {1'b1, a_q.f.frac};
    assign mant_b = (b_q.f.exp == '0) ? '0 : {1'b1, b_q.f.frac};

    assign mul_start = (state == st_smult);

    mant_mul #(
        .mul_bits(mul_bits)
    ) u_mant_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .a      (mant_a),
        .b      (mant_b),
        .product(mul_product),
        .ready  (mul_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (start) begin
            state <= st_smult;
        end else begin
            case (state)
                st_smult: state <= st_mult;
                st_mult: begin
                    if (mul_ready) begin
                        state <= st_norm;
                    end
                end
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
        end else begin
            case (state)
                st_smult: begin
                    res_sign <= a_q.f.sign ^ b_q.f.sign;
                    res_exp  <= a_q.f.exp + b_q.f.exp;
                end
                st_mult: begin
                    if (mul_ready) begin
                        prod    <= mul_product;
                        res_exp <= res_exp - bias_adj;
                    end
                end
                st_norm: begin
                    // Single shift is enough for a 1.x by 1.x product.
                    if (!prod[2*mant_w-1]) begin
                        if (prod == '0) begin
                            res_sign <= 1'b0;
                            res_exp  <= '0;
                        end else begin
                            prod    <= prod << 1;
                            res_exp <= res_exp - exp_w'(1);
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign result.raw = {res_sign, res_exp, prod[2*mant_w-2 -: frac_w]};
    assign ready      = (state == st_idle);

endmodule

// File: hw/fp_add.sv
`timescale 1ns/10ps

module fp_add (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             sub,
    input  fp_pkg::fp_word_u a,
    input  fp_pkg::fp_word_u b,
    output fp_pkg::fp_word_u result,
    output logic             ready
);

    import fp_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_align,
        st_sign,
        st_sum,
        st_norm
    } state_e;

    state_e                   state;
    fp_word_u                 a_q;
    fp_word_u                 b_q;
    logic [mant_w-1:0]        mant_a;
    logic [mant_w-1:0]        mant_b;
    logic signed [mant_w+1:0] al_a;
    logic signed [mant_w+1:0] al_b;
    logic signed [mant_w+1:0] sum;
    logic [mant_w+1:0]        neg_sum;
    logic                     sum_sign;
    logic                     res_sign;
    logic [exp_w-1:0]         res_exp;
    logic [mant_w:0]          mag;
    logic                     norm_done;

    // Zero exponent field reads as zero.
    assign mant_a = (a_q.f.exp == '0) ? '0 : {1'b1, a_q.f.frac};
    assign mant_b = (b_q.f.exp == '0) ? '0 : {1'b1, b_q.f.frac};

    assign sum     = al_a + al_b;
    assign neg_sum = -sum;

    // Carry, hidden bit in place, or nothing left to shift.
    assign norm_done = mag[mant_w] || mag[mant_w-1] || (mag == '0);

    // ====================
    // Control
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (start) begin
            state <= st_align;
        end else begin
            case (state)
                st_align: state <= st_sign;
                st_sign:  state <= st_sum;
                st_sum:   state <= st_norm;
                st_norm: begin
                    if (norm_done) begin
                        state <= st_idle;
                    end
                end
                default:  state <= st_idle;
            endcase
        end
    end

    // ====================
    // Datapath
    // ====================

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            // Subtract is add with b negated.
            b_q.raw <= {b.f.sign ^ sub, b.raw[word_w-2:0]};
        end else begin
            case (state)
                st_align: begin
                    if (a_q.f.exp > b_q.f.exp) begin
                        al_a    <= {2'b00, mant_a};
                        al_b    <= {2'b00, mant_b >> (a_q.f.exp - b_q.f.exp)};
                        res_exp <= a_q.f.exp;
                    end else begin
                        al_a    <= {2'b00, mant_a >> (b_q.f.exp - a_q.f.exp)};
                        al_b    <= {2'b00, mant_b};
                        res_exp <= b_q.f.exp;
                    end
                end
                st_sign: begin
                    if (a_q.f.sign == b_q.f.sign) begin
                        sum_sign <= a_q.f.sign;
                    end else begin
                        sum_sign <= 1'b0;
                        if (a_q.f.sign) begin
                            al_a <= -al_a;
                        end else begin
                            al_b <= -al_b;
                        end
                    end
                end
                st_sum: begin
                    if (sum[mant_w+1]) begin
                        res_sign <= 1'b1;
                        mag      <= neg_sum[mant_w:0];
                    end else begin
                        res_sign <= sum_sign;
                        mag      <= sum[mant_w:0];
                    end
                end
                st_norm: begin
                    if (mag[mant_w]) begin
                        mag     <= mag >> 1;
                        res_exp <= res_exp + exp_w'(1);
                    end else if (!mag[mant_w-1]) begin
                        if (mag == '0) begin
                            res_sign <= 1'b0;
                            res_exp  <= '0;
                        end else begin
                            mag     <= mag << 1;
                            res_exp <= res_exp - exp_w'(1);
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign result.raw = {res_sign, res_exp, mag[frac_w-1:0]};
    assign ready      = (state == st_idle);

endmodule

// File: hw/mant_mul.sv
`timescale 1ns/10ps

module mant_mul #(
    parameter int mul_bits = 6
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [23:0] a,
    input  logic [23:0] b,
    output logic [47:0] product,
    output logic        ready
);

    localparam int width  = 24;
    localparam int prod_w = 2 * width;
    localparam int steps  = width / mul_bits;
    localparam int cnt_w  = $clog2(steps + 1);

    logic [width-1:0]  mplier;
    logic [width-1:0]  mcand;
    logic [prod_w-1:0] acc;
    logic [prod_w-1:0] partial;
    logic [cnt_w-1:0]  step;

    // Top group of the remaining multiplier bits times the multiplicand.
    assign partial = prod_w'(mcand) * prod_w'(mplier[width-1 -: mul_bits]);

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (start) begin
            step <= cnt_w'(steps);
        end else if (step != '0) begin
            step <= step - cnt_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mplier <= a;
            mcand  <= b;
            acc    <= '0;
        end else if (step != '0) begin
            acc    <= partial + (acc << mul_bits);
            mplier <= mplier << mul_bits;
        end
    end

    assign product = acc;
    assign ready   = (step == '0);

endmodule

// File: hw/fp_pkg.sv
package fp_pkg;

    // ====================
    // Binary32 format
    // ====================

    localparam int word_w   = 32;
    localparam int exp_w    = 8;
    localparam int frac_w   = 23;
    localparam int mant_w   = frac_w + 1;
    localparam int exp_bias = 127;

    // ====================
    // Operations
    // ====================

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } fp_op_e;

    // ====================
    // Float word
    // ====================

    typedef struct packed {
        logic              sign;
        logic [exp_w-1:0]  exp;
        logic [frac_w-1:0] frac;
    } fp_fields_s;

    // One word, either as a bus value or split into its fields.
    typedef union packed {
        logic [word_w-1:0] raw;
        fp_fields_s        f;
    } fp_word_u;

endpackage
